//--- compile.f
+incdir+verif
logic/axi3_pkg.sv
logic/mem_pkg.sv
logic/mem_txn_channel.sv
logic/mem_axi3_adapter.sv
logic/axi3_sram.sv
logic/mem_axi3_subsystem.sv
verif/tb_mem_axi3.sv

//--- logic/axi3_pkg.sv
// ------------------------------
// AXI3 bus definitions
// Widths, field encodings and the five channel bundles
// ------------------------------
`default_nettype none

package axi3_pkg;

    // Widths
    localparam int AXI_ADDR_WID   = 32;
    localparam int AXI_DATA_BYTES = 8;
    localparam int AXI_DATA_WID   = AXI_DATA_BYTES * 8;
    localparam int BYTE_SEL_WID   = $clog2(AXI_DATA_BYTES);
    localparam int AXI_ID_WID     = 4;
    localparam int AXI_LEN_WID    = 4;

    // Field encodings
    // ------------------------------
    typedef enum logic [2:0] {
        SIZE_1BYTE    = 3'd0,
        SIZE_2BYTES   = 3'd1,
        SIZE_4BYTES   = 3'd2,
        SIZE_8BYTES   = 3'd3,
        SIZE_16BYTES  = 3'd4,
        SIZE_32BYTES  = 3'd5,
        SIZE_64BYTES  = 3'd6,
        SIZE_128BYTES = 3'd7
    } axsize_e;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10,
        BURST_RSVD  = 2'b11
    } burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // Channel bundles
    // ------------------------------
    // Address bundle, same shape on AW and AR
    typedef struct packed {
        logic [AXI_ID_WID-1:0]   id;
        logic [AXI_ADDR_WID-1:0] addr;
        logic [AXI_LEN_WID-1:0]  len;
        axsize_e                 size;
        burst_e                  burst;
    } ax_t;

    typedef ax_t aw_t;
    typedef ax_t ar_t;

    typedef struct packed {
        logic [AXI_DATA_WID-1:0]   data;
        logic [AXI_DATA_BYTES-1:0] strb;
        logic                      last;
    } w_t;

    typedef struct packed {
        resp_e resp;
    } b_t;

    typedef struct packed {
        logic [AXI_DATA_WID-1:0] data;
        resp_e                   resp;
        logic                    last;
    } r_t;

endpackage : axi3_pkg

`default_nettype wire

//--- logic/axi3_sram.sv
// ------------------------------
// AXI3 word RAM
// Answers OKAY inside a window of words from address zero,
// silently swallows accesses outside it
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi3_sram #(
    parameter int DEPTH_WORDS = 256,
    parameter int RD_LATENCY  = 1
) (
    input  logic          clk,
    input  logic          srst,

    // Write channels
    input  axi3_pkg::aw_t aw,
    input  logic          awvalid,
    output logic          awready,
    input  axi3_pkg::w_t  w,
    input  logic          wvalid,
    output logic          wready,
    output axi3_pkg::b_t  b,
    output logic          bvalid,
    input  logic          bready,

    // Read channels
    input  axi3_pkg::ar_t ar,
    input  logic          arvalid,
    output logic          arready,
    output axi3_pkg::r_t  r,
    output logic          rvalid,
    input  logic          rready
);

    localparam int IDX_WID  = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
    localparam int DATA_WID = axi3_pkg::AXI_DATA_WID;

    logic [DATA_WID-1:0]   mem [DEPTH_WORDS];

    logic                  wr_accept;
    logic                  wr_hs;
    logic                  ar_hs;
    logic [RD_LATENCY-1:0] pipe_vld;
    logic [RD_LATENCY-1:0] pipe_rdy;
    logic [DATA_WID-1:0]   pipe_data [RD_LATENCY];

    function automatic logic in_window(input logic [axi3_pkg::AXI_ADDR_WID-1:0] addr);
        return addr[axi3_pkg::AXI_ADDR_WID-1:axi3_pkg::BYTE_SEL_WID] < DEPTH_WORDS;
    endfunction

    function automatic logic [IDX_WID-1:0] word_idx(
        input logic [axi3_pkg::AXI_ADDR_WID-1:0] addr
    );
        return addr[axi3_pkg::BYTE_SEL_WID +: IDX_WID];
    endfunction

    // Write
    // ------------------------------
    // AW and W are taken together, held off while B is outstanding
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_accept <= 1'b0;
        end else begin
            wr_accept <= awvalid && wvalid && !wr_accept && !bvalid;
        end
    end

    assign awready = wr_accept;
    assign wready  = wr_accept;
    assign wr_hs   = awvalid && wvalid && wr_accept;

    always_ff @(posedge clk) begin
        if (wr_hs && in_window(aw.addr)) begin
            mem[word_idx(aw.addr)] <= w.data;
        end
    end

    // No response at all for the unmapped hole
    always_ff @(posedge clk) begin
        if (srst) begin
            bvalid <= 1'b0;
        end else if (wr_hs && in_window(aw.addr)) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    assign b = '{resp: axi3_pkg::RESP_OKAY};

    // Read
    // ------------------------------
    // Stage 0 is free whenever arready can rise
    always_ff @(posedge clk) begin
        if (srst) begin
            arready <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !pipe_vld[0];
        end
    end

    assign ar_hs = arvalid && arready;

    // A stage moves on when the one after it is empty or moving
    always_comb begin
        pipe_rdy[RD_LATENCY-1] = !pipe_vld[RD_LATENCY-1] || rready;
        for (int i = RD_LATENCY - 2; i >= 0; i--) begin
            pipe_rdy[i] = !pipe_vld[i] || pipe_rdy[i+1];
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            pipe_vld <= '0;
        end else begin
            if (pipe_rdy[0]) begin
                pipe_vld[0] <= ar_hs && in_window(ar.addr);
            end
            for (int i = 1; i < RD_LATENCY; i++) begin
                if (pipe_rdy[i]) begin
                    pipe_vld[i] <= pipe_vld[i-1];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_rdy[0]) begin
            pipe_data[0] <= mem[word_idx(ar.addr)];
        end
        for (int i = 1; i < RD_LATENCY; i++) begin
            if (pipe_rdy[i]) begin
                pipe_data[i] <= pipe_data[i-1];
            end
        end
    end

    assign rvalid = pipe_vld[RD_LATENCY-1];
    assign r = '{
        data: pipe_data[RD_LATENCY-1],
        resp: axi3_pkg::RESP_OKAY,
        last: 1'b1
    };

endmodule : axi3_sram

`default_nettype wire

//--- logic/mem_axi3_adapter.sv
// ------------------------------
// Memory port to AXI3 bridge
// Maps word-addressed write and read ports onto
// single-beat AXI3 bursts, one tracker per direction
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_axi3_adapter #(
    parameter int WR_TIMEOUT = 64,
    parameter int RD_TIMEOUT = 64
) (
    input  logic              clk,
    input  logic              srst,

    // Upstream write port
    input  logic              wr_req,
    input  mem_pkg::wr_req_t  wr,
    output logic              wr_rdy,
    output logic              wr_ack,
    output mem_pkg::wr_rsp_t  wr_rsp,

    // Upstream read port
    input  logic              rd_req,
    input  mem_pkg::rd_req_t  rd,
    output logic              rd_rdy,
    output logic              rd_ack,
    output mem_pkg::rd_rsp_t  rd_rsp,

    // AXI3 write channels
    output axi3_pkg::aw_t     aw,
    output logic              awvalid,
    input  logic              awready,
    output axi3_pkg::w_t      w,
    output logic              wvalid,
    input  logic              wready,
    input  axi3_pkg::b_t      b,
    input  logic              bvalid,
    output logic              bready,

    // AXI3 read channels
    output axi3_pkg::ar_t     ar,
    output logic              arvalid,
    input  logic              arready,
    input  axi3_pkg::r_t      r,
    input  logic              rvalid,
    output logic              rready
);

    localparam mem_pkg::wr_rsp_t WR_TIMEOUT_RSP = '{resp: axi3_pkg::RESP_SLVERR};
    localparam mem_pkg::rd_rsp_t RD_TIMEOUT_RSP = '{resp: axi3_pkg::RESP_SLVERR, data: '0};

    mem_pkg::wr_req_t wr_pkt;
    mem_pkg::rd_req_t rd_pkt;
    mem_pkg::wr_rsp_t b_rsp;
    mem_pkg::rd_rsp_t r_rsp;
    logic [1:0]       wr_chan_valid;

    // Word address to byte address, upper bits zero
    function automatic logic [axi3_pkg::AXI_ADDR_WID-1:0] byte_addr(
        input logic [mem_pkg::WORD_ADDR_WID-1:0] word_addr
    );
        logic [axi3_pkg::AXI_ADDR_WID-1:0] addr;
        addr = '0;
        addr[axi3_pkg::BYTE_SEL_WID +: mem_pkg::WORD_ADDR_WID] = word_addr;
        return addr;
    endfunction

    // Write path
    // ------------------------------
    // AW on channel 0, W on channel 1
    mem_txn_channel #(
        .REQ_T       (mem_pkg::wr_req_t),
        .RSP_T       (mem_pkg::wr_rsp_t),
        .NUM_REQ_CH  (2),
        .TIMEOUT     (WR_TIMEOUT),
        .TIMEOUT_RSP (WR_TIMEOUT_RSP)
    ) u_wr_chan (
        .clk          (clk),
        .srst         (srst),
        .req          (wr_req),
        .req_payload  (wr),
        .rdy          (wr_rdy),
        .ack          (wr_ack),
        .rsp          (wr_rsp),
        .chan_valid   (wr_chan_valid),
        .chan_ready   ({wready, awready}),
        .chan_payload (wr_pkt),
        .rsp_valid    (bvalid),
        .rsp_ready    (bready),
        .rsp_payload  (b_rsp)
    );

    assign awvalid = wr_chan_valid[0];
    assign wvalid  = wr_chan_valid[1];

    assign aw = '{
        id:    '0,
        addr:  byte_addr(wr_pkt.addr),
        len:   '0,
        size:  axi3_pkg::SIZE_8BYTES,
        burst: axi3_pkg::BURST_INCR
    };
    assign w     = '{data: wr_pkt.data, strb: '1, last: 1'b1};
    assign b_rsp = '{resp: b.resp};

    // Read path
    // ------------------------------
    mem_txn_channel #(
        .REQ_T       (mem_pkg::rd_req_t),
        .RSP_T       (mem_pkg::rd_rsp_t),
        .NUM_REQ_CH  (1),
        .TIMEOUT     (RD_TIMEOUT),
        .TIMEOUT_RSP (RD_TIMEOUT_RSP)
    ) u_rd_chan (
        .clk          (clk),
        .srst         (srst),
        .req          (rd_req),
        .req_payload  (rd),
        .rdy          (rd_rdy),
        .ack          (rd_ack),
        .rsp          (rd_rsp),
        .chan_valid   (arvalid),
        .chan_ready   (arready),
        .chan_payload (rd_pkt),
        .rsp_valid    (rvalid),
        .rsp_ready    (rready),
        .rsp_payload  (r_rsp)
    );

    assign ar = '{
        id:    '0,
        addr:  byte_addr(rd_pkt.addr),
        len:   '0,
        size:  axi3_pkg::SIZE_8BYTES,
        burst: axi3_pkg::BURST_INCR
    };
    assign r_rsp = '{resp: r.resp, data: r.data};

endmodule : mem_axi3_adapter

`default_nettype wire

//--- logic/mem_axi3_subsystem.sv
// ------------------------------
// Memory port over AXI3 subsystem
// Bridge plus AXI3 RAM behind it
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_axi3_subsystem #(
    parameter int WR_TIMEOUT  = 64,
    parameter int RD_TIMEOUT  = 64,
    parameter int DEPTH_WORDS = 256,
    parameter int RD_LATENCY  = 1
) (
    input  logic             clk,
    input  logic             srst,

    // Write port
    input  logic             wr_req,
    input  mem_pkg::wr_req_t wr,
    output logic             wr_rdy,
    output logic             wr_ack,
    output mem_pkg::wr_rsp_t wr_rsp,

    // Read port
    input  logic             rd_req,
    input  mem_pkg::rd_req_t rd,
    output logic             rd_rdy,
    output logic             rd_ack,
    output mem_pkg::rd_rsp_t rd_rsp
);

    // Internal AXI3 bus
    // ------------------------------
    axi3_pkg::aw_t aw;
    axi3_pkg::w_t  w;
    axi3_pkg::b_t  b;
    axi3_pkg::ar_t ar;
    axi3_pkg::r_t  r;
    logic          awvalid;
    logic          awready;
    logic          wvalid;
    logic          wready;
    logic          bvalid;
    logic          bready;
    logic          arvalid;
    logic          arready;
    logic          rvalid;
    logic          rready;

    mem_axi3_adapter #(
        .WR_TIMEOUT (WR_TIMEOUT),
        .RD_TIMEOUT (RD_TIMEOUT)
    ) u_adapter (
        .clk     (clk),
        .srst    (srst),
        .wr_req  (wr_req),
        .wr      (wr),
        .wr_rdy  (wr_rdy),
        .wr_ack  (wr_ack),
        .wr_rsp  (wr_rsp),
        .rd_req  (rd_req),
        .rd      (rd),
        .rd_rdy  (rd_rdy),
        .rd_ack  (rd_ack),
        .rd_rsp  (rd_rsp),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    axi3_sram #(
        .DEPTH_WORDS (DEPTH_WORDS),
        .RD_LATENCY  (RD_LATENCY)
    ) u_sram (
        .clk     (clk),
        .srst    (srst),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule : mem_axi3_subsystem

`default_nettype wire

//--- logic/mem_pkg.sv
// ------------------------------
// Upstream memory port definitions
// Word-addressed request and response structs
// ------------------------------
`default_nettype none

package mem_pkg;

    localparam int WORD_ADDR_WID = 16;
    // One memory word fills the whole AXI data bus
    localparam int DATA_WID      = axi3_pkg::AXI_DATA_BYTES * 8;

    // Requests
    typedef struct packed {
        logic [WORD_ADDR_WID-1:0] addr;
        logic [DATA_WID-1:0]      data;
    } wr_req_t;

    typedef struct packed {
        logic [WORD_ADDR_WID-1:0] addr;
    } rd_req_t;

    // Responses
    typedef struct packed {
        axi3_pkg::resp_e resp;
    } wr_rsp_t;

    typedef struct packed {
        axi3_pkg::resp_e     resp;
        logic [DATA_WID-1:0] data;
    } rd_rsp_t;

endpackage : mem_pkg

`default_nettype wire

//--- logic/mem_txn_channel.sv
// ------------------------------
// Single-outstanding transaction tracker
// Issues a request on one or more channels, waits for the
// response and acks it, or acks a fixed response on timeout
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_txn_channel #(
    parameter type REQ_T       = logic,
    parameter type RSP_T       = logic,
    parameter int  NUM_REQ_CH  = 1,
    parameter int  TIMEOUT     = 64,
    parameter RSP_T TIMEOUT_RSP = '0
) (
    input  logic                  clk,
    input  logic                  srst,

    // Upstream
    input  logic                  req,
    input  REQ_T                  req_payload,
    output logic                  rdy,
    output logic                  ack,
    output RSP_T                  rsp,

    // Downstream request channels
    output logic [NUM_REQ_CH-1:0] chan_valid,
    input  logic [NUM_REQ_CH-1:0] chan_ready,
    output REQ_T                  chan_payload,

    // Downstream response channel
    input  logic                  rsp_valid,
    output logic                  rsp_ready,
    input  RSP_T                  rsp_payload
);

    logic accept;
    logic pending;
    logic waiting;
    logic rsp_fire;
    logic timeout;

    assign accept   = req && rdy;
    assign rdy      = !pending;
    // Waiting for the response, ready drops once it is taken
    assign waiting  = pending && rsp_ready;
    assign rsp_fire = waiting && rsp_valid;

    // Transaction state
    // ------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (ack) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            chan_payload <= req_payload;
        end
    end

    // Each request channel drops on its own ready
    always_ff @(posedge clk) begin
        if (srst) begin
            chan_valid <= '0;
        end else if (accept) begin
            chan_valid <= '1;
        end else begin
            chan_valid <= chan_valid & ~chan_ready & {NUM_REQ_CH{!timeout}};
        end
    end

    // Timeout
    // ------------------------------
    generate
        if (TIMEOUT > 0) begin : g_timer
            localparam int TIMER_WID = $clog2(TIMEOUT + 1);

            logic [TIMER_WID-1:0] timer;

            always_ff @(posedge clk) begin
                if (srst) begin
                    timer <= '0;
                end else if (accept) begin
                    timer <= '0;
                end else if (waiting && (timer != TIMER_WID'(TIMEOUT))) begin
                    timer <= timer + 1'b1;
                end
            end

            // Fires TIMEOUT cycles after acceptance
            assign timeout = waiting && (timer == TIMER_WID'(TIMEOUT));
        end else begin : g_no_timer
            assign timeout = 1'b0;
        end
    endgenerate

    // Response
    // ------------------------------
    // While idle, stray responses are taken and dropped
    always_ff @(posedge clk) begin
        if (srst) begin
            rsp_ready <= 1'b0;
        end else if (accept) begin
            rsp_ready <= 1'b1;
        end else if (pending) begin
            if (rsp_fire || timeout) begin
                rsp_ready <= 1'b0;
            end
        end else begin
            rsp_ready <= rsp_valid && !rsp_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            ack <= 1'b0;
        end else begin
            ack <= rsp_fire || timeout;
        end
    end

    // A real response wins over a timeout in the same cycle
    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            rsp <= rsp_payload;
        end else if (timeout) begin
            rsp <= TIMEOUT_RSP;
        end
    end

endmodule : mem_txn_channel

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the memory port over AXI3 simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal \
    -f compile.f \
    --top-module tb_mem_axi3 \
    -Mdir obj_dir

./obj_dir/Vtb_mem_axi3 | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1

//--- verif/tb_mem_model.svh
// ------------------------------
// Reference memory model
// Expected words per address and expected port responses
// ------------------------------
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// Expected contents, keyed by word address
logic [mem_pkg::DATA_WID-1:0] model_mem [logic [mem_pkg::WORD_ADDR_WID-1:0]];

function automatic logic in_window(input logic [mem_pkg::WORD_ADDR_WID-1:0] addr);
    return int'(addr) < DEPTH_WORDS;
endfunction

// Preload pattern, every address bit shows up in the word
function automatic logic [mem_pkg::DATA_WID-1:0] fill_word(
    input logic [mem_pkg::WORD_ADDR_WID-1:0] addr
);
    return {addr, ~addr, addr ^ 16'hc35a, addr + 16'h1e0f};
endfunction

// Writes into the hole are lost
function automatic void model_write(
    input logic [mem_pkg::WORD_ADDR_WID-1:0] addr,
    input logic [mem_pkg::DATA_WID-1:0]      data
);
    if (in_window(addr)) begin
        model_mem[addr] = data;
    end
endfunction

function automatic mem_pkg::wr_rsp_t exp_wr_rsp(input logic [mem_pkg::WORD_ADDR_WID-1:0] addr);
    mem_pkg::wr_rsp_t rsp;
    rsp.resp = axi3_pkg::RESP_SLVERR;
    if (in_window(addr)) begin
        rsp.resp = axi3_pkg::RESP_OKAY;
    end
    return rsp;
endfunction

// Hole reads end by timeout with zero data
function automatic mem_pkg::rd_rsp_t exp_rd_rsp(input logic [mem_pkg::WORD_ADDR_WID-1:0] addr);
    mem_pkg::rd_rsp_t rsp;
    rsp.resp = axi3_pkg::RESP_SLVERR;
    rsp.data = '0;
    if (in_window(addr)) begin
        rsp.resp = axi3_pkg::RESP_OKAY;
        rsp.data = model_mem[addr];
    end
    return rsp;
endfunction

`endif

//--- verif/tb_mem_axi3.sv
// ------------------------------
// Testbench for the memory port over AXI3 subsystem
// Directed and random traffic on both ports against a model
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_mem_axi3;

    localparam int WR_TIMEOUT  = 16;
    localparam int RD_TIMEOUT  = 16;
    localparam int DEPTH_WORDS = 256;
    localparam int RD_LATENCY  = 3;
    localparam int WAIT_LIMIT  = 64;
    localparam int NUM_RANDOM  = 400;

    logic             clk;
    logic             srst;
    logic             wr_req;
    mem_pkg::wr_req_t wr;
    logic             wr_rdy;
    logic             wr_ack;
    mem_pkg::wr_rsp_t wr_rsp;
    logic             rd_req;
    mem_pkg::rd_req_t rd;
    logic             rd_rdy;
    logic             rd_ack;
    mem_pkg::rd_rsp_t rd_rsp;

    int          checks;
    int          val_errors;
    int          other_errors;
    int          wr_issued;
    int          rd_issued;
    int          wr_acks;
    int          rd_acks;
    logic [31:0] lcg_state;

    `include "tb_mem_model.svh"

    mem_axi3_subsystem #(
        .WR_TIMEOUT  (WR_TIMEOUT),
        .RD_TIMEOUT  (RD_TIMEOUT),
        .DEPTH_WORDS (DEPTH_WORDS),
        .RD_LATENCY  (RD_LATENCY)
    ) dut (
        .clk    (clk),
        .srst   (srst),
        .wr_req (wr_req),
        .wr     (wr),
        .wr_rdy (wr_rdy),
        .wr_ack (wr_ack),
        .wr_rsp (wr_rsp),
        .rd_req (rd_req),
        .rd     (rd),
        .rd_rdy (rd_rdy),
        .rd_ack (rd_ack),
        .rd_rsp (rd_rsp)
    );

    always #20 clk = ~clk;

    // Ack pulses counted for the final comparison with accepted requests
    always @(negedge clk) begin
        if (wr_ack) begin
            wr_acks++;
        end
        if (rd_ack) begin
            rd_acks++;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Only upper LCG bits since the low ones repeat quickly
    function automatic logic [15:0] draw_addr();
        logic [31:0] r;
        r = next_rand();
        if (r[31:29] == 3'd0) begin
            return 16'(DEPTH_WORDS) + (r[27:12] % 16'hff00);
        end
        return 16'(r[27:20]);
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s expected %h, got %h at %0t ns", name, exp, got, $time);
            val_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Failure: %s at %0t ns", what, $time);
            other_errors++;
        end
    endtask

    // Port drivers entered on a falling edge
    // ------------------------------
    task automatic do_write(input logic [15:0] addr, input logic [63:0] data, input logic hold);
        int               edges;
        mem_pkg::wr_rsp_t exp;
        exp = exp_wr_rsp(addr);
        edges = 0;
        while (!wr_rdy && edges < WAIT_LIMIT) begin
            @(negedge clk);
            edges++;
        end
        check_true(wr_rdy, "write port never became ready");
        wr_req = 1'b1;
        wr = '{addr: addr, data: data};
        @(negedge clk);
        wr_issued++;
        // A held request must not be taken again
        wr_req = hold;
        edges = 0;
        while (!wr_ack && edges < WAIT_LIMIT) begin
            check_val("wr_rdy", wr_rdy, 0);
            @(negedge clk);
            edges++;
        end
        wr_req = 1'b0;
        check_true(wr_ack, "write got no ack");
        // Still busy in the ack cycle
        check_val("wr_rdy", wr_rdy, 0);
        check_val("wr_rsp.resp", wr_rsp.resp, exp.resp);
        if (!in_window(addr)) begin
            check_val("write timeout latency", edges, WR_TIMEOUT + 1);
        end
        model_write(addr, data);
        @(negedge clk);
        check_val("wr_ack", wr_ack, 0);
        check_val("wr_rdy", wr_rdy, 1);
    endtask

    task automatic do_read(input logic [15:0] addr, input logic hold);
        int               edges;
        mem_pkg::rd_rsp_t exp;
        exp = exp_rd_rsp(addr);
        edges = 0;
        while (!rd_rdy && edges < WAIT_LIMIT) begin
            @(negedge clk);
            edges++;
        end
        check_true(rd_rdy, "read port never became ready");
        rd_req = 1'b1;
        rd = '{addr: addr};
        @(negedge clk);
        rd_issued++;
        rd_req = hold;
        edges = 0;
        while (!rd_ack && edges < WAIT_LIMIT) begin
            check_val("rd_rdy", rd_rdy, 0);
            @(negedge clk);
            edges++;
        end
        rd_req = 1'b0;
        check_true(rd_ack, "read got no ack");
        check_val("rd_rdy", rd_rdy, 0);
        check_val("rd_rsp.resp", rd_rsp.resp, exp.resp);
        check_val("rd_rsp.data", rd_rsp.data, exp.data);
        if (!in_window(addr)) begin
            check_val("read timeout latency", edges, RD_TIMEOUT + 1);
        end
        @(negedge clk);
        check_val("rd_ack", rd_ack, 0);
        check_val("rd_rdy", rd_rdy, 1);
    endtask

    // Main sequence
    // ------------------------------
    initial begin
        logic [15:0] wa;
        logic [15:0] ra;
        logic [63:0] wd;
        logic [31:0] ctl;
        clk = 1'b0;
        srst = 1'b1;
        wr_req = 1'b0;
        rd_req = 1'b0;
        wr = '0;
        rd = '0;
        checks = 0;
        val_errors = 0;
        other_errors = 0;
        wr_issued = 0;
        rd_issued = 0;
        wr_acks = 0;
        rd_acks = 0;
        lcg_state = 32'h6f81_fb6e;
        repeat (5) @(posedge clk);
        @(negedge clk);
        srst = 1'b0;
        check_val("wr_ack", wr_ack, 0);
        check_val("rd_ack", rd_ack, 0);
        check_val("wr_rdy", wr_rdy, 1);
        check_val("rd_rdy", rd_rdy, 1);

        // Fill the whole window so every read has a known word
        for (int a = 0; a < DEPTH_WORDS; a++) begin
            do_write(16'(a), fill_word(16'(a)), 1'b0);
        end

        do_write(16'h0042, 64'h0123_4567_89ab_cdef, 1'b0);
        do_read(16'h0042, 1'b0);
        // Unmapped hole followed by normal traffic
        do_write(16'h1234, 64'hdead_beef_cafe_f00d, 1'b0);
        do_read(16'h8000, 1'b0);
        do_read(16'h0042, 1'b0);
        do_write(16'h00ff, 64'h5555_aaaa_0f0f_f0f0, 1'b0);
        do_read(16'h00ff, 1'b0);
        // Requests held high while pending
        do_write(16'h0010, 64'h1111_2222_3333_4444, 1'b1);
        do_read(16'h0010, 1'b1);
        do_read(16'h0300, 1'b1);

        // Both ports at once on different addresses
        for (int i = 0; i < NUM_RANDOM / 2; i++) begin
            wa = draw_addr();
            ra = draw_addr();
            if (ra == wa) begin
                ra = ra ^ 16'h0001;
            end
            wd = {next_rand(), next_rand()};
            ctl = next_rand();
            fork
                begin
                    repeat (ctl[31:30]) @(negedge clk);
                    do_write(wa, wd, ctl[27]);
                end
                begin
                    repeat (ctl[29:28]) @(negedge clk);
                    do_read(ra, ctl[26]);
                end
            join
        end

        repeat (4) @(negedge clk);
        check_val("write ack count", wr_acks, wr_issued);
        check_val("read ack count", rd_acks, rd_issued);
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, val_errors, other_errors);
        if (val_errors + other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : tb_mem_axi3

`default_nettype wire
